// File: filelist.f
+incdir+include
hdl/g729Pkg.sv
hdl/framePacer.sv
hdl/subframeIndexer.sv
hdl/stepDecoder.sv
hdl/stepController.sv
hdl/g729Sequencer.sv
sim/engineModel.sv
sim/g729SequencerTb.sv

// File: hdl/framePacer.sv
`include "g729_settings.svh"

module framePacer import g729Pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic analysisReady
);

	logic armed;
	paceCount_t frameCount;
	logic lastFrame;

	assign lastFrame = (frameCount == paceCount_t'(`G729_FRAMES_PER_ANALYSIS - 1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			armed <= 1'b0;
			frameCount <= '0;
			analysisReady <= 1'b0;
		end
		else
		begin
			analysisReady <= 1'b0; // Single cycle pulse
			if (start)
				armed <= 1'b1; // Stays armed until reset
			if (armed && frameDone)
			begin
				if (lastFrame)
				begin
					frameCount <= '0;
					analysisReady <= 1'b1;
				end
				else
					frameCount <= frameCount + 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		frameCount < paceCount_t'(`G729_FRAMES_PER_ANALYSIS));

endmodule

// File: hdl/g729Pkg.sv
`include "g729_settings.svh"

package g729Pkg;

	// Engine steps run in enum order, so an engine step's successor is step + 1
	typedef enum logic [`G729_STEP_WIDTH-1:0]
	{
		stepIdle,
		stepWaitAnalysis,
		stepAutocorr, stepLag, stepLevinson, stepAz, stepQuaLsp, // LPC analysis
		stepIntLpc, stepIntQlpc, stepMath1, stepPercVar,
		stepWeightAz1, stepWeightAz2, stepResidu1, stepSynFilt1, // Whole frame passes
		stepWeightAz3, stepWeightAz4, stepResidu2, stepSynFilt2,
		stepPitchOl, stepMath2,
		stepLoopTest, // Subframe loop head
		stepWeightAz5, stepWeightAz6, stepMath3,
		stepSynFilt3, stepSynFilt4, stepResidu3, stepSynFilt5, stepResidu4, stepSynFilt6,
		stepPitchFr3, stepEncLag3, stepLoadAnalysis, stepCheckParity,
		stepParityPitch, stepPredLt3, stepConvolve, stepGPitch,
		stepLoopNext,
		stepFrameEnd
	} step_t;

	// One bit per analysis engine, used for start and done alike
	typedef struct packed
	{
		logic autocorr;
		logic lag;
		logic levinson;
		logic az;
		logic quaLsp;
		logic intLpc;
		logic intQlpc;
		logic math1;
		logic percVar;
		logic weightAz;
		logic residu;
		logic synFilt;
		logic pitchOl;
		logic math2;
		logic math3;
		logic pitchFr3;
		logic encLag3;
		logic parityPitch;
		logic predLt3;
		logic convolve;
		logic gPitch;
	} engines_t;

	// Parameter register strobes, load or clear
	typedef struct packed
	{
		logic tOp;
		logic t0;
		logic t0Min;
		logic t0Max;
		logic t0Frac;
		logic gainPit;
		logic index;
		logic aAddr;
		logic aqAddr;
		logic iSubfr; // Internal indexer only
		logic iGamma; // Internal indexer only
	} regStrobes_t;

	typedef logic subframe_t;
	typedef logic [1:0] gamma_t;
	typedef logic [`G729_PACE_WIDTH-1:0] paceCount_t;
	typedef logic [`G729_MUX_WIDTH-1:0] muxSel_t;

	// Index strobes stay inside the sequencer
	function automatic regStrobes_t externalStrobes(input regStrobes_t strobes);
		regStrobes_t result;
		result = strobes;
		result.iSubfr = 1'b0;
		result.iGamma = 1'b0;
		return result;
	endfunction

endpackage

// File: hdl/g729Sequencer.sv
`include "g729_settings.svh"

module g729Sequencer import g729Pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameDone,
	input engines_t engineDone,
	output engines_t engineStart,
	output muxSel_t mathMuxSel,
	output regStrobes_t regLoad,
	output regStrobes_t regClear,
	output subframe_t subframe,
	output gamma_t gamma,
	output logic frameComplete
);

	logic analysisReady;
	step_t step;
	engines_t stepEngine;
	regStrobes_t loadInternal;
	regStrobes_t clearInternal;

	framePacer framePacer_i
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.analysisReady(analysisReady)
	);

	stepDecoder stepDecoder_i
	(
		.step(step),
		.stepEngine(stepEngine),
		.mathMuxSel(mathMuxSel)
	);

	stepController stepController_i
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.analysisReady(analysisReady),
		.engineDone(engineDone),
		.stepEngine(stepEngine),
		.subframe(subframe),
		.step(step),
		.engineStart(engineStart),
		.regLoad(loadInternal),
		.regClear(clearInternal),
		.frameComplete(frameComplete)
	);

	subframeIndexer subframeIndexer_i
	(
		.clock(clock),
		.reset(reset),
		.clearSubframe(clearInternal.iSubfr),
		.advanceSubframe(loadInternal.iSubfr),
		.clearGamma(clearInternal.iGamma),
		.advanceGamma(loadInternal.iGamma),
		.subframe(subframe),
		.gamma(gamma)
	);

	assign regLoad = externalStrobes(loadInternal); // Index bits stay inside
	assign regClear = externalStrobes(clearInternal);

endmodule

// File: hdl/stepController.sv
`include "g729_settings.svh"

module stepController import g729Pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic analysisReady,
	input engines_t engineDone,
	input engines_t stepEngine,
	input subframe_t subframe,
	output step_t step,
	output engines_t engineStart,
	output regStrobes_t regLoad,
	output regStrobes_t regClear,
	output logic frameComplete
);

	step_t stepNext;
	logic startIssued; // Engine of this step already started
	logic stepDone;
	logic lastSubframe;
	logic loopFinished; // Last subframe has finished its pitch gain

	assign stepDone = |(engineDone & stepEngine); // Other engines' done bits ignored
	assign lastSubframe = (subframe == subframe_t'(`G729_SUBFRAMES - 1));
	assign frameComplete = (step == stepFrameEnd);
	assign engineStart = startIssued ? engines_t'('0) : stepEngine;

	////////////////////////////////////////////////////////////////////////////
	// Next step and register strobes
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		stepNext = step;
		regLoad = '0;
		regClear = '0;

		case (step)
			stepIdle:
			begin
				regClear = '1; // Parameter registers held clear while idle
				if (start)
					stepNext = stepWaitAnalysis;
			end
			stepWaitAnalysis:
				if (analysisReady)
					stepNext = stepAutocorr;
			stepLoopTest:
			begin
				if (loopFinished)
				begin
					regClear.iSubfr = 1'b1;
					regClear.iGamma = 1'b1;
					stepNext = stepFrameEnd;
				end
				else
					stepNext = stepWeightAz5;
			end
			stepLoadAnalysis:
				stepNext = stepCheckParity;
			stepCheckParity:
				stepNext = (subframe == '0) ? stepParityPitch : stepPredLt3;
			stepLoopNext:
			begin
				regLoad.aAddr = 1'b1; // Next subframe's filter coefficients
				regLoad.aqAddr = 1'b1;
				stepNext = stepLoopTest;
			end
			stepFrameEnd:
				stepNext = stepIdle;
			default:
				if (stepDone)
					stepNext = step_t'(step + 1'b1); // Chain follows enum order
		endcase

		// Strobes fired as an engine step exits
		if (stepDone)
		begin
			case (step)
				stepPitchOl:
					regLoad.tOp = 1'b1;
				stepMath2:
				begin
					regLoad.t0Min = 1'b1;
					regLoad.t0Max = 1'b1;
					regLoad.aAddr = 1'b1;
					regLoad.aqAddr = 1'b1;
					regClear.iGamma = 1'b1;
				end
				stepMath3:
					regLoad.iGamma = 1'b1;
				stepPitchFr3:
				begin
					regLoad.t0 = 1'b1;
					regLoad.t0Frac = 1'b1;
				end
				stepEncLag3:
				begin
					regLoad.index = 1'b1;
					regLoad.t0Min = 1'b1;
					regLoad.t0Max = 1'b1;
				end
				stepGPitch:
				begin
					regLoad.gainPit = 1'b1;
					regLoad.iSubfr = !lastSubframe; // Index stops at the last subframe
				end
				default:
					regLoad.tOp = 1'b0;
			endcase
		end

		if (divErr)
			stepNext = stepIdle; // Abort from any step
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			step <= stepIdle;
			startIssued <= 1'b0;
			loopFinished <= 1'b0;
		end
		else
		begin
			step <= stepNext;
			startIssued <= (stepNext == step); // Rearms on every step change
			if (step == stepIdle)
				loopFinished <= 1'b0;
			else if (stepDone && step == stepGPitch && lastSubframe)
				loopFinished <= 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (reset) $onehot0(engineStart));

	// Frame end only follows the loop test of a finished loop
	assert property (@(posedge clock) disable iff (reset)
		frameComplete |-> $past(step) == stepLoopTest && $past(loopFinished));

endmodule

// File: hdl/stepDecoder.sv
`include "g729_settings.svh"

module stepDecoder import g729Pkg::*;
(
	input step_t step,
	output engines_t stepEngine,
	output muxSel_t mathMuxSel
);

	always_comb
	begin
		stepEngine = '0; // Control steps call no engine
		mathMuxSel = '0;

		////////////////////////////////////////////////////////////////////////////
		// Engine called by each step
		////////////////////////////////////////////////////////////////////////////
		case (step)
			stepAutocorr : stepEngine.autocorr = 1'b1;
			stepLag : stepEngine.lag = 1'b1;
			stepLevinson : stepEngine.levinson = 1'b1;
			stepAz : stepEngine.az = 1'b1;
			stepQuaLsp : stepEngine.quaLsp = 1'b1;
			stepIntLpc : stepEngine.intLpc = 1'b1;
			stepIntQlpc : stepEngine.intQlpc = 1'b1;
			stepMath1 : stepEngine.math1 = 1'b1;
			stepPercVar : stepEngine.percVar = 1'b1;
			stepWeightAz1, stepWeightAz2, stepWeightAz3, stepWeightAz4,
			stepWeightAz5, stepWeightAz6 : stepEngine.weightAz = 1'b1;
			stepResidu1, stepResidu2, stepResidu3, stepResidu4 : stepEngine.residu = 1'b1;
			stepSynFilt1, stepSynFilt2, stepSynFilt3, stepSynFilt4,
			stepSynFilt5, stepSynFilt6 : stepEngine.synFilt = 1'b1;
			stepPitchOl : stepEngine.pitchOl = 1'b1;
			stepMath2 : stepEngine.math2 = 1'b1;
			stepMath3 : stepEngine.math3 = 1'b1;
			stepPitchFr3 : stepEngine.pitchFr3 = 1'b1;
			stepEncLag3 : stepEngine.encLag3 = 1'b1;
			stepParityPitch : stepEngine.parityPitch = 1'b1;
			stepPredLt3 : stepEngine.predLt3 = 1'b1;
			stepConvolve : stepEngine.convolve = 1'b1;
			stepGPitch : stepEngine.gPitch = 1'b1;
			default : stepEngine = '0;
		endcase

		////////////////////////////////////////////////////////////////////////////
		// Math unit operand routing
		////////////////////////////////////////////////////////////////////////////
		case (step)
			stepAutocorr : mathMuxSel = muxSel_t'(0);
			stepLag : mathMuxSel = muxSel_t'(1);
			stepLevinson : mathMuxSel = muxSel_t'(2);
			stepAz : mathMuxSel = muxSel_t'(3);
			stepQuaLsp : mathMuxSel = muxSel_t'(4);
			stepIntLpc : mathMuxSel = muxSel_t'(5);
			stepIntQlpc : mathMuxSel = muxSel_t'(6);
			stepMath1 : mathMuxSel = muxSel_t'(7);
			stepPercVar : mathMuxSel = muxSel_t'(8);
			stepWeightAz1 : mathMuxSel = muxSel_t'(9);
			stepWeightAz2 : mathMuxSel = muxSel_t'(10);
			stepResidu1 : mathMuxSel = muxSel_t'(11);
			stepSynFilt1 : mathMuxSel = muxSel_t'(12);
			stepWeightAz3 : mathMuxSel = muxSel_t'(13);
			stepWeightAz4 : mathMuxSel = muxSel_t'(14);
			stepResidu2 : mathMuxSel = muxSel_t'(15);
			stepSynFilt2 : mathMuxSel = muxSel_t'(16);
			stepPitchOl : mathMuxSel = muxSel_t'(17);
			stepMath2 : mathMuxSel = muxSel_t'(18);
			stepWeightAz5 : mathMuxSel = muxSel_t'(19);
			stepWeightAz6 : mathMuxSel = muxSel_t'(20);
			stepMath3 : mathMuxSel = muxSel_t'(21);
			stepSynFilt3 : mathMuxSel = muxSel_t'(22);
			stepSynFilt4 : mathMuxSel = muxSel_t'(23);
			stepResidu3 : mathMuxSel = muxSel_t'(24);
			stepSynFilt5 : mathMuxSel = muxSel_t'(25);
			stepResidu4 : mathMuxSel = muxSel_t'(26);
			stepSynFilt6 : mathMuxSel = muxSel_t'(27);
			stepPitchFr3 : mathMuxSel = muxSel_t'(28);
			stepEncLag3 : mathMuxSel = muxSel_t'(29);
			stepLoadAnalysis : mathMuxSel = muxSel_t'(30); // Analysis buffer load
			stepParityPitch : mathMuxSel = muxSel_t'(31);
			stepPredLt3 : mathMuxSel = muxSel_t'(32);
			stepConvolve : mathMuxSel = muxSel_t'(33);
			stepGPitch : mathMuxSel = muxSel_t'(34);
			default : mathMuxSel = '0;
		endcase
	end

endmodule

// File: hdl/subframeIndexer.sv
`include "g729_settings.svh"

module subframeIndexer import g729Pkg::*;
(
	input logic clock,
	input logic reset,
	input logic clearSubframe,
	input logic advanceSubframe,
	input logic clearGamma,
	input logic advanceGamma,
	output subframe_t subframe,
	output gamma_t gamma
);

	localparam subframe_t subframeLast = subframe_t'(`G729_SUBFRAMES - 1);
	localparam gamma_t gammaLast = gamma_t'(`G729_SUBFRAMES * `G729_GAMMA_STEPS - 1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			subframe <= '0;
			gamma <= '0;
		end
		else
		begin
			if (clearSubframe)
				subframe <= '0; // Clear wins
			else if (advanceSubframe)
				subframe <= subframe + 1'b1;

			if (clearGamma)
				gamma <= '0;
			else if (advanceGamma)
				gamma <= gamma + 1'b1;
		end
	end

	// The controller must never step an index past its last value
	assert property (@(posedge clock) disable iff (reset)
		advanceSubframe && !clearSubframe |-> subframe != subframeLast);

	assert property (@(posedge clock) disable iff (reset)
		advanceGamma && !clearGamma |-> gamma != gammaLast);

endmodule

// File: include/g729_settings.svh
`ifndef G729_SETTINGS_SVH
`define G729_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Subframe loop
////////////////////////////////////////////////////////////////////////////

`define G729_SUBFRAMES 2 // Subframes per frame
`define G729_GAMMA_STEPS 2 // Gamma index advances per subframe

////////////////////////////////////////////////////////////////////////////
// Frame pacing
////////////////////////////////////////////////////////////////////////////

`define G729_FRAMES_PER_ANALYSIS 2 // Input frames per analysis run
`define G729_PACE_WIDTH 2 // Holds 0 to ratio - 1

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

`define G729_MUX_WIDTH 6 // Math unit multiplexer select
`define G729_STEP_WIDTH 6 // Sequencer step encoding

`endif

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module g729SequencerTb -f filelist.f

./obj_dir/Vg729SequencerTb 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failures"

// File: sim/engineModel.sv
`include "g729_settings.svh"

module engineModel import g729Pkg::*;
(
	input logic clock,
	input logic reset,
	input engines_t engineStart,
	output engines_t engineDone
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int engineCount = $bits(engines_t);

	logic [31:0] lfsr;
	logic [engineCount-1:0] startBits;
	logic [engineCount-1:0] doneNext;
	logic [2:0] delayBits;
	int countdown [engineCount]; // Cycles left until each engine's done

	assign startBits = engineStart;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	initial
	begin
		lfsr = 32'h22a3;
		engineDone = '0;
	end

	always @(posedge clock)
	begin
		#1; // Same drive point as the testbench
		for (int i = 0; i < engineCount; i++)
		begin
			doneNext[i] = 1'b0;
			if (reset)
				countdown[i] = 0;
			else if (countdown[i] != 0)
			begin
				countdown[i] = countdown[i] - 1;
				doneNext[i] = (countdown[i] == 0);
			end
			if (!reset && startBits[i])
			begin
				for (int b = 0; b < 3; b++)
				begin
					lfsr = lfsrNext(lfsr); // One step per bit taken
					delayBits[b] = lfsr[0];
				end
				countdown[i] = int'(delayBits) + 1; // 1 to 8 cycles
			end
		end
		engineDone = engines_t'(doneNext);
	end

endmodule

// File: sim/g729SequencerTb.sv
`include "g729_settings.svh"

module g729SequencerTb import g729Pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int maxDelay = 8;
	localparam int callsPerFrame = 48; // 19 before the loop, then 15 and 14
	localparam int frameCycles = callsPerFrame * (maxDelay + 1) + 40;
	localparam int cycleLimit = 4 * frameCycles + 50;
	localparam int engineCount = $bits(engines_t);
	localparam int parityPos = 17;
	localparam int math3Pos = 14;

	// Engine positions in struct order, autocorr is 0 and gPitch is 20
	localparam int analysisEngine [19] =
		'{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 9, 10, 11, 9, 9, 10, 11, 12, 13};
	localparam int loopEngine [15] =
		'{9, 9, 14, 11, 11, 10, 11, 10, 11, 15, 16, 17, 18, 19, 20};
	localparam int loopSel [15] =
		'{19, 20, 21, 22, 23, 24, 25, 26, 27, 28, 29, 31, 32, 33, 34};

	logic clock;
	logic reset;
	logic start;
	logic divErr;
	logic frameDone;
	engines_t engineDone;
	engines_t engineStart;
	muxSel_t mathMuxSel;
	regStrobes_t regLoad;
	regStrobes_t regClear;
	regStrobes_t idleClear;
	subframe_t subframe;
	gamma_t gamma;
	logic frameComplete;

	engines_t expEngine [64];
	muxSel_t expSel [64];
	subframe_t expSub [64];
	gamma_t expGamma [64];
	int callTotal;

	logic startSeen;
	logic busy; // An engine was started and its done is still due
	logic aborted;
	engines_t pending;
	int callIndex;
	int framesSinceStart;
	int gainPitLoads;
	int framesCompleted;
	engines_t expectedStart;
	muxSel_t expectedSel;
	subframe_t expectedSubframe;
	gamma_t expectedGamma;

	string testName;
	int testErrors;
	int testsRun;
	int testsFailed;
	int totalErrors;
	int cycleCount;

	g729Sequencer g729Sequencer_i
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameDone(frameDone),
		.engineDone(engineDone),
		.engineStart(engineStart),
		.mathMuxSel(mathMuxSel),
		.regLoad(regLoad),
		.regClear(regClear),
		.subframe(subframe),
		.gamma(gamma),
		.frameComplete(frameComplete)
	);

	engineModel engineModel_i
	(
		.clock(clock),
		.reset(reset),
		.engineStart(engineStart),
		.engineDone(engineDone)
	);

	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic valueMismatch(input string check, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h", testName, check,
			expected, actual);
		testErrors++;
		totalErrors++;
	endtask

	task automatic ruleBroken(input string what);
		$display("ERROR in %s: %s", testName, what);
		testErrors++;
		totalErrors++;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		testsRun++;
		if (testErrors == 0)
			$display("PASS %s", testName);
		else
		begin
			testsFailed++;
			$display("FAIL %s with %0d errors", testName, testErrors);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected engine calls of one frame
	////////////////////////////////////////////////////////////////////////////

	task automatic addCall(input int position, input int sel, input int sub, input int gam);
		logic [engineCount-1:0] bits;
		bits = '0;
		bits[engineCount - 1 - position] = 1'b1; // First field is the MSB
		expEngine[callTotal] = engines_t'(bits);
		expSel[callTotal] = muxSel_t'(sel);
		expSub[callTotal] = subframe_t'(sub);
		expGamma[callTotal] = gamma_t'(gam);
		callTotal++;
	endtask

	task automatic buildExpected();
		int gammaCount;
		callTotal = 0;
		gammaCount = 0;
		for (int i = 0; i < 19; i++)
			addCall(analysisEngine[i], i, 0, 0); // Select counts up until math step 2
		for (int sub = 0; sub < `G729_SUBFRAMES; sub++)
			for (int i = 0; i < 15; i++)
			begin
				if (loopEngine[i] != parityPos || sub == 0)
					addCall(loopEngine[i], loopSel[i], sub, gammaCount);
				if (loopEngine[i] == math3Pos)
					gammaCount++; // Gamma steps on after math step 3
			end
	endtask

	always_comb
	begin
		expectedStart = '0;
		expectedSel = '0;
		expectedSubframe = '0;
		expectedGamma = '0;
		if (callIndex < callTotal)
		begin
			expectedStart = expEngine[callIndex];
			expectedSel = expSel[callIndex];
			expectedSubframe = expSub[callIndex];
			expectedGamma = expGamma[callIndex];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitors
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			startSeen <= 1'b0;
			busy <= 1'b0;
			aborted <= 1'b0;
			pending <= '0;
			callIndex <= 0;
			framesSinceStart <= 0;
			gainPitLoads <= 0;
			framesCompleted <= 0;
		end
		else
		begin
			if (start)
			begin
				startSeen <= 1'b1;
				aborted <= 1'b0;
				callIndex <= 0; // Each start begins a new frame
				framesSinceStart <= 0;
				gainPitLoads <= 0;
			end
			if (frameDone)
				framesSinceStart <= framesSinceStart + 1;
			if (engineStart != '0)
			begin
				busy <= 1'b1;
				pending <= engineStart;
				callIndex <= callIndex + 1;
			end
			else if (busy && (engineDone & pending) != '0)
				busy <= 1'b0;
			if (regLoad.gainPit)
				gainPitLoads <= gainPitLoads + 1;
			if (divErr)
				aborted <= 1'b1;
			if (frameComplete)
				framesCompleted <= framesCompleted + 1;
		end
	end

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: no frame end within %0d cycles in %s", cycleLimit, testName);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (reset)
		!startSeen |-> engineStart == '0 && regLoad == '0 && !frameComplete
			&& regClear == idleClear)
		else ruleBroken("outputs not in the idle state before the first start");

	assert property (@(posedge clock) disable iff (reset) $onehot0(engineStart))
		else ruleBroken("more than one engine started at once");

	assert property (@(posedge clock) disable iff (reset)
		engineStart != '0 |-> framesSinceStart >= `G729_FRAMES_PER_ANALYSIS)
		else ruleBroken("engine started before the second input frame");

	assert property (@(posedge clock) disable iff (reset)
		engineStart != '0 |-> !busy)
		else ruleBroken("engine started before the previous engine was done");

	assert property (@(posedge clock) disable iff (reset)
		engineStart != '0 |-> engineStart == expectedStart)
		else valueMismatch("engine start", 32'($sampled(expectedStart)),
			32'($sampled(engineStart)));

	assert property (@(posedge clock) disable iff (reset)
		engineStart != '0 |-> mathMuxSel == expectedSel)
		else valueMismatch("math mux select", 32'($sampled(expectedSel)),
			32'($sampled(mathMuxSel)));

	assert property (@(posedge clock) disable iff (reset)
		engineStart != '0 |-> subframe == expectedSubframe)
		else valueMismatch("subframe index", 32'($sampled(expectedSubframe)),
			32'($sampled(subframe)));

	assert property (@(posedge clock) disable iff (reset)
		engineStart != '0 |-> gamma == expectedGamma)
		else valueMismatch("gamma index", 32'($sampled(expectedGamma)),
			32'($sampled(gamma)));

	assert property (@(posedge clock) disable iff (reset)
		frameComplete |-> callIndex == callTotal && !busy)
		else ruleBroken("frame completed before the last pitch gain was done");

	assert property (@(posedge clock) disable iff (reset)
		frameComplete |-> gainPitLoads == `G729_SUBFRAMES)
		else valueMismatch("gain pitch loads", `G729_SUBFRAMES, $sampled(gainPitLoads));

	assert property (@(posedge clock) disable iff (reset) frameComplete |-> !aborted)
		else ruleBroken("frame completed after a divide error");

	assert property (@(posedge clock) disable iff (reset)
		$past(divErr) |-> engineStart == '0 && regClear == idleClear)
		else ruleBroken("divide error did not return the sequencer to idle");

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	task automatic pulseFrameDone();
		frameDone = 1'b1;
		nextCycle();
		frameDone = 1'b0;
	endtask

	// Abort once abortAt engines have started, zero runs the whole frame
	task automatic runFrame(input int abortAt);
		int completions;
		completions = framesCompleted;
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		repeat (2) nextCycle();
		pulseFrameDone();
		repeat (3) nextCycle();
		pulseFrameDone();
		if (abortAt > 0)
		begin
			while (callIndex < abortAt)
				nextCycle();
			divErr = 1'b1;
			nextCycle();
			divErr = 1'b0;
			// Long enough for the rest of an unaborted frame to finish
			repeat ((callsPerFrame - abortAt) * (maxDelay + 1) + 20) nextCycle();
			assert (framesCompleted == completions)
				else valueMismatch("frames completed", completions, framesCompleted);
		end
		else
		begin
			while (framesCompleted == completions)
				nextCycle();
			repeat (2) nextCycle(); // A repeated frame end would show here
			assert (framesCompleted == completions + 1)
				else valueMismatch("frames completed", completions + 1, framesCompleted);
		end
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		frameDone = 1'b0;
		idleClear = '1;
		idleClear.iSubfr = 1'b0; // Index clears stay inside the DUT
		idleClear.iGamma = 1'b0;
		cycleCount = 0;
		testsRun = 0;
		testsFailed = 0;
		totalErrors = 0;
		testErrors = 0;
		testName = "reset";
		buildExpected();
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		beginTest("resetState");
		repeat (8) nextCycle();
		endTest();
		beginTest("pacingAndOrder");
		runFrame(0);
		endTest();
		beginTest("secondFrame");
		runFrame(0);
		endTest();
		beginTest("divideAbort");
		runFrame(20); // Mid loop of the first subframe
		endTest();
		beginTest("frameAfterAbort");
		runFrame(0);
		endTest();

		$display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed,
			totalErrors);
		if (testsFailed == 0 && totalErrors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
